/* ctrl_core_pkg.sv */
// Shared widths, register map and reset constants of the control core
// All bus writes are full 32-bit words, select lines are not used
// Settings indexes are 8 bits wide and come from byte address bits 9 to 2

package ctrl_core_pkg;

   // ////////////////////
   // Bus widths
   localparam int WB_DW  = 32;
   localparam int WB_AW  = 16;
   localparam int SET_AW = 8;
   localparam int TIME_W = 64;

   typedef logic [WB_DW-1:0]  wb_data_t;
   typedef logic [WB_AW-1:0]  wb_addr_t;
   typedef logic [SET_AW-1:0] set_addr_t;
   typedef logic [TIME_W-1:0] vita_time_t;

   // ////////////////////
   // Region decode on byte address bits 15 to 8
   localparam logic [7:0] SETTINGS_REGION = 8'h70;
   localparam logic [7:0] SETTINGS_MASK   = 8'hF0;
   localparam logic [7:0] READBACK_REGION = 8'h5C;
   localparam logic [7:0] READBACK_MASK   = 8'hFC;

   // Readback words, index from address bits 5 to 2
   localparam int RB_WORDS = 16;

   // ////////////////////
   // Settings register indexes
   localparam set_addr_t SR_MISC      = 8'd0;
   localparam set_addr_t SR_LMS_RES   = SR_MISC + 8'd0;
   localparam set_addr_t SR_LED_SW    = SR_MISC + 8'd3;
   localparam set_addr_t SR_PHY_RESET = SR_MISC + 8'd4;
   localparam set_addr_t SR_BLDR_DONE = SR_MISC + 8'd5;
   localparam set_addr_t SR_LED_SRC   = SR_MISC + 8'd6;
   // High word at +0, low word at +1
   localparam set_addr_t SR_TIME64    = 8'd10;
   // Switch 1 at +0, switch 2 at +1
   localparam set_addr_t SR_DIVSW     = 8'd180;

   // Reset values
   localparam logic [7:0] LED_SRC_RESET = 8'h1E;
   localparam logic       DIVSW_RESET   = 1'b1;

   // Major in the upper half, minor in the lower half
   localparam wb_data_t COMPAT_NUM_DEFAULT = {16'd9, 16'd0};

endpackage

/* boot_reset_ctrl.sv */
// Bootloader reset controller
// Issues one extra core reset when software reports boot done
// Only power-on reset brings the FSM back to the wait state

`timescale 1ns/1ps

module boot_reset_ctrl (
   input  logic clk_i,
   input  logic por_rst_i,
   input  logic bldr_done_i,
   output logic core_rst_o,
   output logic boot_done_o
);

   typedef enum logic {
      BLDR_WAIT = 1'b0,
      BLDR_DONE = 1'b1
   } bldr_state_t;

   bldr_state_t state;

   always_ff @(posedge clk_i) begin
      if (por_rst_i) begin
         state      <= BLDR_WAIT;
         core_rst_o <= 1'b1;
      end else begin
         core_rst_o <= 1'b0;
         case (state)
            BLDR_WAIT: begin
               // Bootloader flag resets the core once
               if (bldr_done_i) begin
                  state      <= BLDR_DONE;
                  core_rst_o <= 1'b1;
               end
            end
            default: begin
               // Stay here until power-on reset
               state <= BLDR_DONE;
            end
         endcase
      end
   end

   assign boot_done_o = (state == BLDR_DONE);

endmodule

/* wb_slave_decode.sv */
// Wishbone classic decode for the settings and readback regions
// Unmapped addresses and writes to the read-only readback region
// get a local ack with zero data so the bus never hangs

`timescale 1ns/1ps

module wb_slave_decode (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   cyc_i,
   input  logic                   stb_i,
   input  logic                   we_i,
   input  ctrl_core_pkg::wb_addr_t adr_i,
   input  ctrl_core_pkg::wb_data_t dat_i,
   output logic                   set_cyc_o,
   output logic                   set_stb_o,
   output logic                   set_we_o,
   output ctrl_core_pkg::wb_data_t set_dat_o,
   output logic                   rb_stb_o,
   input  logic                   set_ack_i,
   input  logic                   rb_ack_i,
   input  ctrl_core_pkg::wb_data_t rb_dat_i,
   output logic                   ack_o,
   output ctrl_core_pkg::wb_data_t dat_o
);

   import ctrl_core_pkg::*;

   logic [7:0] region;
   logic       set_hit;
   logic       rb_sel;
   logic       unmapped_req;
   logic       unmapped_ack;

   assign region  = adr_i[WB_AW-1:WB_AW-8];
   assign set_hit = (region & SETTINGS_MASK) == SETTINGS_REGION;
   // Readback only takes reads
   assign rb_sel  = ((region & READBACK_MASK) == READBACK_REGION) & ~we_i;

   // ////////////////////
   // Request routing
   assign set_cyc_o = cyc_i & set_hit;
   assign set_stb_o = stb_i & set_hit;
   assign set_we_o  = we_i & set_hit;
   assign set_dat_o = set_hit ? dat_i : '0;
   assign rb_stb_o  = cyc_i & stb_i & rb_sel;

   assign unmapped_req = cyc_i & stb_i & ~set_hit & ~rb_sel;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         unmapped_ack <= 1'b0;
      end else begin
         unmapped_ack <= unmapped_req & ~unmapped_ack;
      end
   end

   // ////////////////////
   // Response merge
   assign ack_o = set_ack_i | rb_ack_i | unmapped_ack;
   assign dat_o = rb_sel ? rb_dat_i : '0;

endmodule

/* settings_regs.sv */
// Settings bus write port and board control registers
// Registers update on the edge that raises ack
// The settings strobe follows on that edge for blocks that decode it later
// Reads are acked here and the data path returns zero

`timescale 1ns/1ps

module settings_regs (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    cyc_i,
   input  logic                    stb_i,
   input  logic                    we_i,
   input  ctrl_core_pkg::wb_addr_t  adr_i,
   input  ctrl_core_pkg::wb_data_t  dat_i,
   input  logic [3:0]              run_i,
   output logic                    ack_o,
   output logic                    set_stb_o,
   output ctrl_core_pkg::set_addr_t set_addr_o,
   output ctrl_core_pkg::wb_data_t  set_data_o,
   output logic [1:0]              lms_res_o,
   output logic                    phy_reset_n_o,
   output logic                    bldr_done_o,
   output logic [1:0]              divsw_o,
   output logic [7:0]              leds_o
);

   import ctrl_core_pkg::*;

   logic       accept;
   logic       wr_en;
   set_addr_t  wr_idx;
   logic       phy_reset;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   assign accept = cyc_i & stb_i & ~ack_o;
   assign wr_en  = accept & we_i;
   assign wr_idx = adr_i[SET_AW+1:2];

   // ////////////////////
   // Bus handshake and settings strobe
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o     <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         ack_o     <= accept;
         set_stb_o <= wr_en;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         set_addr_o <= wr_idx;
         set_data_o <= dat_i;
      end
   end

   // ////////////////////
   // Control registers
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         lms_res_o   <= 2'b00;
         led_sw      <= 8'h00;
         phy_reset   <= 1'b0;
         bldr_done_o <= 1'b0;
         led_src     <= LED_SRC_RESET;
         divsw_o     <= {DIVSW_RESET, DIVSW_RESET};
      end else if (wr_en) begin
         case (wr_idx)
            SR_LMS_RES:     lms_res_o   <= dat_i[1:0];
            SR_LED_SW:      led_sw      <= dat_i[7:0];
            SR_PHY_RESET:   phy_reset   <= dat_i[0];
            SR_BLDR_DONE:   bldr_done_o <= dat_i[0];
            SR_LED_SRC:     led_src     <= dat_i[7:0];
            SR_DIVSW:       divsw_o[0]  <= dat_i[0];
            SR_DIVSW + 8'd1: divsw_o[1] <= dat_i[0];
            default: begin
               // Index owned by another block
            end
         endcase
      end
   end

   // PHY reset pin is active low
   assign phy_reset_n_o = ~phy_reset;

   // ////////////////////
   // LED mix where a set led_src bit selects hardware
   assign led_hw = {3'b000, run_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

/* readback_mux.sv */
// Registered 16-word readback slave
// Data is captured when the request is sampled and shown with ack
// High and low halves of a time are separate reads and may not match

`timescale 1ns/1ps

module readback_mux #(
   parameter ctrl_core_pkg::wb_data_t COMPAT_NUM = ctrl_core_pkg::COMPAT_NUM_DEFAULT
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     stb_i,
   input  ctrl_core_pkg::wb_addr_t   adr_i,
   input  ctrl_core_pkg::wb_data_t   status_i,
   input  logic [1:0]               aux_ld_i,
   input  logic                     button_i,
   input  ctrl_core_pkg::vita_time_t vita_time_i,
   input  ctrl_core_pkg::vita_time_t vita_time_pps_i,
   output logic                     ack_o,
   output ctrl_core_pkg::wb_data_t   dat_o
);

   import ctrl_core_pkg::*;

   localparam int RB_IW = $clog2(RB_WORDS);

   wb_data_t         words [RB_WORDS];
   logic [RB_IW-1:0] word_idx;
   logic             accept;

   assign word_idx = adr_i[RB_IW+1:2];
   assign accept   = stb_i & ~ack_o;

   // ////////////////////
   // Word map
   always_comb begin
      for (int i = 0; i < RB_WORDS; i++) begin
         words[i] = '0;
      end
      words[8]  = status_i;
      words[10] = vita_time_i[63:32];
      words[11] = vita_time_i[31:0];
      words[12] = COMPAT_NUM;
      // ld2, ld1, button in bits 18 to 16
      words[13] = {13'b0, aux_ld_i[1], aux_ld_i[0], button_i, 16'b0};
      words[14] = vita_time_pps_i[63:32];
      words[15] = vita_time_pps_i[31:0];
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= accept;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         dat_o <= words[word_idx];
      end
   end

endmodule

/* vita_timer.sv */
// Loadable 64-bit time counter on the bus clock
// Load order is high word at TIME_BASE, then low word at TIME_BASE+1
// The low write loads both halves, a lone high write changes nothing yet
// PPS is asynchronous, the latch lands 3 edges after pps_i is sampled high

`timescale 1ns/1ps

module vita_timer #(
   parameter ctrl_core_pkg::set_addr_t TIME_BASE = ctrl_core_pkg::SR_TIME64
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     set_stb_i,
   input  ctrl_core_pkg::set_addr_t  set_addr_i,
   input  ctrl_core_pkg::wb_data_t   set_data_i,
   input  logic                     pps_i,
   output ctrl_core_pkg::vita_time_t vita_time_o,
   output ctrl_core_pkg::vita_time_t vita_time_pps_o
);

   import ctrl_core_pkg::*;

   wb_data_t time_hi_pend;
   logic     load_hi;
   logic     load_lo;
   logic     pps_meta;
   logic     pps_sync;
   logic     pps_dly;
   logic     pps_pulse;

   assign load_hi = set_stb_i && (set_addr_i == TIME_BASE);
   assign load_lo = set_stb_i && (set_addr_i == TIME_BASE + 8'd1);

   // ////////////////////
   // Counter and load
   always_ff @(posedge clk_i) begin
      if (load_hi) begin
         time_hi_pend <= set_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         vita_time_o <= '0;
      end else if (load_lo) begin
         vita_time_o <= {time_hi_pend, set_data_i};
      end else begin
         vita_time_o <= vita_time_o + 1'b1;
      end
   end

   // ////////////////////
   // PPS synchronizer, rising edge and latch
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pps_meta  <= 1'b0;
         pps_sync  <= 1'b0;
         pps_dly   <= 1'b0;
         pps_pulse <= 1'b0;
      end else begin
         pps_meta  <= pps_i;
         pps_sync  <= pps_meta;
         pps_dly   <= pps_sync;
         pps_pulse <= pps_sync & ~pps_dly;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         vita_time_pps_o <= '0;
      end else if (pps_pulse) begin
         vita_time_pps_o <= vita_time_o;
      end
   end

endmodule

/* ctrl_core.sv */
// Control-plane slice of the radio core, one Wishbone classic slave
// Everything runs on wb_clk, pps_i and status inputs are taken as is
// Settings at 0x7000, readback at 0x5C00, other addresses ack with zero

`timescale 1ns/1ps

module ctrl_core #(
   parameter ctrl_core_pkg::wb_data_t  COMPAT_NUM = ctrl_core_pkg::COMPAT_NUM_DEFAULT,
   parameter ctrl_core_pkg::set_addr_t TIME_BASE  = ctrl_core_pkg::SR_TIME64
) (
   input  logic                    wb_clk,
   input  logic                    por_rst,
   input  logic                    wb_cyc_i,
   input  logic                    wb_stb_i,
   input  logic                    wb_we_i,
   input  ctrl_core_pkg::wb_addr_t  wb_adr_i,
   input  ctrl_core_pkg::wb_data_t  wb_dat_i,
   output logic                    wb_ack_o,
   output ctrl_core_pkg::wb_data_t  wb_dat_o,
   input  logic [3:0]              run_i,
   input  ctrl_core_pkg::wb_data_t  status_i,
   input  logic [1:0]              aux_ld_i,
   input  logic                    button_i,
   input  logic                    pps_i,
   output logic [7:0]              leds_o,
   output logic [1:0]              lms_res_o,
   output logic                    phy_reset_n_o,
   output logic [1:0]              divsw_o,
   output logic                    boot_done_o
);

   import ctrl_core_pkg::*;

   logic       core_rst;
   logic       bldr_done;

   // Bus side toward the two slaves
   logic       sr_cyc;
   logic       sr_stb;
   logic       sr_we;
   wb_data_t   sr_dat;
   logic       sr_ack;
   logic       rb_stb;
   logic       rb_ack;
   wb_data_t   rb_dat;

   // Settings bus
   logic       set_stb;
   set_addr_t  set_addr;
   wb_data_t   set_data;

   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   // ////////////////////
   // Reset
   boot_reset_ctrl boot_reset_ctrl_inst (
      .clk_i       (wb_clk),
      .por_rst_i   (por_rst),
      .bldr_done_i (bldr_done),
      .core_rst_o  (core_rst),
      .boot_done_o (boot_done_o)
   );

   // ////////////////////
   // Bus decode and slaves
   wb_slave_decode wb_slave_decode_inst (
      .clk_i     (wb_clk),
      .rst_i     (core_rst),
      .cyc_i     (wb_cyc_i),
      .stb_i     (wb_stb_i),
      .we_i      (wb_we_i),
      .adr_i     (wb_adr_i),
      .dat_i     (wb_dat_i),
      .set_cyc_o (sr_cyc),
      .set_stb_o (sr_stb),
      .set_we_o  (sr_we),
      .set_dat_o (sr_dat),
      .rb_stb_o  (rb_stb),
      .set_ack_i (sr_ack),
      .rb_ack_i  (rb_ack),
      .rb_dat_i  (rb_dat),
      .ack_o     (wb_ack_o),
      .dat_o     (wb_dat_o)
   );

   settings_regs settings_regs_inst (
      .clk_i         (wb_clk),
      .rst_i         (core_rst),
      .cyc_i         (sr_cyc),
      .stb_i         (sr_stb),
      .we_i          (sr_we),
      .adr_i         (wb_adr_i),
      .dat_i         (sr_dat),
      .run_i         (run_i),
      .ack_o         (sr_ack),
      .set_stb_o     (set_stb),
      .set_addr_o    (set_addr),
      .set_data_o    (set_data),
      .lms_res_o     (lms_res_o),
      .phy_reset_n_o (phy_reset_n_o),
      .bldr_done_o   (bldr_done),
      .divsw_o       (divsw_o),
      .leds_o        (leds_o)
   );

   readback_mux #(
      .COMPAT_NUM (COMPAT_NUM)
   ) readback_mux_inst (
      .clk_i           (wb_clk),
      .rst_i           (core_rst),
      .stb_i           (rb_stb),
      .adr_i           (wb_adr_i),
      .status_i        (status_i),
      .aux_ld_i        (aux_ld_i),
      .button_i        (button_i),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .ack_o           (rb_ack),
      .dat_o           (rb_dat)
   );

   // ////////////////////
   // Time
   vita_timer #(
      .TIME_BASE (TIME_BASE)
   ) vita_timer_inst (
      .clk_i           (wb_clk),
      .rst_i           (core_rst),
      .set_stb_i       (set_stb),
      .set_addr_i      (set_addr),
      .set_data_i      (set_data),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps)
   );

endmodule

/* tb_ctrl_core.sv */
// Self-checking testbench for the control core
// Random stimulus from a fixed seed is checked against a register model
// Inputs change and outputs are sampled on the falling edge

`timescale 1ns/1ps

module tb_ctrl_core;

   import ctrl_core_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int N_WRITES   = 200;
   localparam int N_READS    = 64;
   localparam int ACK_LIMIT  = 16;
   // Rough length of each test in cycles
   localparam int RESET_LEN  = 20;
   localparam int WRITE_LEN  = N_WRITES * 4;
   localparam int READ_LEN   = (N_READS + 16) * 4;
   localparam int TIME_LEN   = 40;
   localparam int BOOT_LEN   = 40;
   localparam int MARGIN     = 4;
   localparam int RUN_LEN    = RESET_LEN + WRITE_LEN + READ_LEN + TIME_LEN + BOOT_LEN;

   logic       wb_clk;
   logic       por_rst;
   logic       wb_cyc_i;
   logic       wb_stb_i;
   logic       wb_we_i;
   wb_addr_t   wb_adr_i;
   wb_data_t   wb_dat_i;
   logic       wb_ack_o;
   wb_data_t   wb_dat_o;
   logic [3:0] run_i;
   wb_data_t   status_i;
   logic [1:0] aux_ld_i;
   logic       button_i;
   logic       pps_i;
   logic [7:0] leds_o;
   logic [1:0] lms_res_o;
   logic       phy_reset_n_o;
   logic [1:0] divsw_o;
   logic       boot_done_o;

   int              seed = 5211;
   int              errors = 0;
   int              checks = 0;
   int              tests = 0;
   int              start_errs;
   int              waited;
   longint unsigned cycle_cnt = 0;
   longint unsigned load_cycle;
   set_addr_t       idx;
   wb_data_t        wdata;
   wb_data_t        rdata;
   wb_addr_t        addr;
   logic [3:0]      word;
   logic [63:0]     wtime;
   logic [63:0]     got;
   logic [63:0]     low_bound;
   logic [63:0]     high_bound;

   // Owned indexes first, then indexes that no register here decodes
   set_addr_t write_idx [12] = '{8'd0, 8'd3, 8'd4, 8'd6, 8'd180, 8'd181,
                                 8'd1, 8'd2, 8'd7, 8'd9, 8'd100, 8'd255};

   // Register model
   logic [1:0] m_lms_res;
   logic [7:0] m_led_sw;
   logic       m_phy_reset;
   logic [7:0] m_led_src;
   logic [1:0] m_divsw;
   logic       m_boot_done;

   ctrl_core ctrl_core_inst (
      .wb_clk        (wb_clk),
      .por_rst       (por_rst),
      .wb_cyc_i      (wb_cyc_i),
      .wb_stb_i      (wb_stb_i),
      .wb_we_i       (wb_we_i),
      .wb_adr_i      (wb_adr_i),
      .wb_dat_i      (wb_dat_i),
      .wb_ack_o      (wb_ack_o),
      .wb_dat_o      (wb_dat_o),
      .run_i         (run_i),
      .status_i      (status_i),
      .aux_ld_i      (aux_ld_i),
      .button_i      (button_i),
      .pps_i         (pps_i),
      .leds_o        (leds_o),
      .lms_res_o     (lms_res_o),
      .phy_reset_n_o (phy_reset_n_o),
      .divsw_o       (divsw_o),
      .boot_done_o   (boot_done_o)
   );

   initial begin
      wb_clk = 1'b0;
      forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   initial begin
      #(RUN_LEN * MARGIN * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not finish", RUN_LEN * MARGIN);
      $display("Simulation FAILED");
      $finish;
   end

   // ////////////////////
   // Model
   task automatic model_reset();
      m_lms_res   = 2'b00;
      m_led_sw    = 8'h00;
      m_phy_reset = 1'b0;
      m_led_src   = 8'h1E;
      m_divsw     = 2'b11;
   endtask

   task automatic model_write(input set_addr_t index, input wb_data_t data);
      case (index)
         8'd0:   m_lms_res   = data[1:0];
         8'd3:   m_led_sw    = data[7:0];
         8'd4:   m_phy_reset = data[0];
         8'd6:   m_led_src   = data[7:0];
         8'd180: m_divsw[0]  = data[0];
         8'd181: m_divsw[1]  = data[0];
         default: begin
         end
      endcase
   endtask

   // Each LED takes the hardware bit where led_src is set
   function automatic logic [7:0] expected_leds(input logic [3:0] run);
      logic [7:0] hw;
      logic [7:0] leds;
      hw = {3'b000, run, 1'b0};
      for (int i = 0; i < 8; i++) begin
         leds[i] = m_led_src[i] ? hw[i] : m_led_sw[i];
      end
      return leds;
   endfunction

   // PPS words read zero until the first PPS edge
   function automatic wb_data_t expected_rb(input logic [3:0] index);
      case (index)
         4'd8:    return status_i;
         4'd12:   return 32'h0009_0000;
         4'd13:   return {13'd0, aux_ld_i, button_i, 16'd0};
         default: return 32'd0;
      endcase
   endfunction

   // ////////////////////
   // Checks and reporting
   task automatic check_value(input string name, input logic [63:0] val,
                              input logic [63:0] exp);
      checks++;
      if (val !== exp) begin
         $display("error: %s got 0x%0h expected 0x%0h", name, val, exp);
         errors++;
      end
   endtask

   task automatic check_outputs();
      check_value("lms_res_o", lms_res_o, m_lms_res);
      check_value("phy_reset_n_o", phy_reset_n_o, !m_phy_reset);
      check_value("divsw_o", divsw_o, m_divsw);
      check_value("leds_o", leds_o, expected_leds(run_i));
      check_value("boot_done_o", boot_done_o, m_boot_done);
   endtask

   task automatic report_test(input string name, input int first_err);
      tests++;
      $display("test %-14s %s with %0d errors", name,
               (errors == first_err) ? "done" : "broken", errors - first_err);
   endtask

   // ////////////////////
   // Bus tasks
   task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
                             output wb_data_t rd);
      int cnt;
      cnt = 0;
      @(negedge wb_clk);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = dat;
      do begin
         @(negedge wb_clk);
         cnt++;
      end while (!wb_ack_o && cnt < ACK_LIMIT);
      rd = wb_dat_o;
      if (!wb_ack_o) begin
         $display("%s at address 0x%h was never acknowledged", we ? "write" : "read", adr);
         errors++;
      end else if (cnt != 1) begin
         $display("ack for address 0x%h came after %0d cycles instead of one", adr, cnt);
         errors++;
      end
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic write_setting(input set_addr_t index, input wb_data_t dat);
      wb_data_t unused;
      bus_access(1'b1, {4'h7, 2'b00, index, 2'b00}, dat, unused);
   endtask

   task automatic read_word(input wb_addr_t adr, output wb_data_t rd);
      bus_access(1'b0, adr, 32'd0, rd);
   endtask

   // ////////////////////
   // Test sequence
   initial begin
      por_rst     = 1'b1;
      wb_cyc_i    = 1'b0;
      wb_stb_i    = 1'b0;
      wb_we_i     = 1'b0;
      wb_adr_i    = '0;
      wb_dat_i    = '0;
      run_i       = 4'h0;
      status_i    = '0;
      aux_ld_i    = 2'b00;
      button_i    = 1'b0;
      pps_i       = 1'b0;
      m_boot_done = 1'b0;
      model_reset();
      repeat (8) @(negedge wb_clk);
      por_rst = 1'b0;
      repeat (3) @(negedge wb_clk);

      start_errs = errors;
      run_i = 4'($random(seed));
      @(negedge wb_clk);
      check_value("wb_ack_o", wb_ack_o, 0);
      check_outputs();
      report_test("reset_state", start_errs);

      start_errs = errors;
      for (int n = 0; n < N_WRITES; n++) begin
         idx   = write_idx[$unsigned($random(seed)) % 12];
         wdata = $random(seed);
         @(negedge wb_clk);
         run_i = 4'($random(seed));
         write_setting(idx, wdata);
         model_write(idx, wdata);
         check_outputs();
      end
      report_test("settings_write", start_errs);

      start_errs = errors;
      for (int n = 0; n < N_READS; n++) begin
         @(negedge wb_clk);
         status_i = $random(seed);
         aux_ld_i = 2'($random(seed));
         button_i = 1'($random(seed));
         word     = 4'($random(seed));
         read_word({8'h5C, 2'b00, word, 2'b00}, rdata);
         // Running time words are covered by the time test
         if (word != 4'd10 && word != 4'd11) begin
            check_value($sformatf("wb_dat_o word %0d", word), rdata, expected_rb(word));
         end
      end
      // Unmapped and settings-region reads return zero
      for (int n = 0; n < 16; n++) begin
         addr = 16'($random(seed));
         addr[15:12] = n[0] ? 4'h7 : 4'h1;
         addr[1:0] = 2'b00;
         read_word(addr, rdata);
         check_value("wb_dat_o", rdata, 0);
      end
      report_test("readback", start_errs);

      start_errs = errors;
      // Low word kept far from a carry so the halves agree
      wtime = {32'($random(seed)), 32'($random(seed)) & 32'h0FFF_FFFF};
      write_setting(8'd10, wtime[63:32]);
      write_setting(8'd11, wtime[31:0]);
      load_cycle = cycle_cnt;
      read_word(16'h5C28, rdata);
      got[63:32] = rdata;
      read_word(16'h5C2C, rdata);
      got[31:0] = rdata;
      checks++;
      if (got < wtime || got > wtime + (cycle_cnt - load_cycle)) begin
         $display("error: vita_time got 0x%0h expected 0x%0h to 0x%0h",
                  got, wtime, wtime + (cycle_cnt - load_cycle));
         errors++;
      end
      @(negedge wb_clk);
      pps_i = 1'b1;
      // Counter now plus 3 edges of latency with one cycle of slack
      low_bound  = wtime + (cycle_cnt - load_cycle - 1) + 2;
      high_bound = low_bound + 2;
      repeat (8) @(negedge wb_clk);
      pps_i = 1'b0;
      read_word(16'h5C38, rdata);
      got[63:32] = rdata;
      read_word(16'h5C3C, rdata);
      got[31:0] = rdata;
      checks++;
      if (got < low_bound || got > high_bound) begin
         $display("error: vita_time_pps got 0x%0h expected 0x%0h to 0x%0h",
                  got, low_bound, high_bound);
         errors++;
      end
      report_test("time_pps", start_errs);

      start_errs = errors;
      // Bit 0 is a software LED under the reset led_src
      wdata = $random(seed) | 32'h1;
      write_setting(8'd3, wdata);
      model_write(8'd3, wdata);
      write_setting(8'd5, 32'd1);
      waited = 0;
      while (!boot_done_o && waited < ACK_LIMIT) begin
         @(negedge wb_clk);
         waited++;
      end
      if (!boot_done_o) begin
         $display("boot_done_o never rose after the bootloader flag was written");
         errors++;
      end
      repeat (3) @(negedge wb_clk);
      model_reset();
      m_boot_done = 1'b1;
      check_outputs();
      // Second flag write must not reset again
      wdata = $random(seed) | 32'h1;
      write_setting(8'd3, wdata);
      model_write(8'd3, wdata);
      write_setting(8'd5, 32'd1);
      repeat (6) @(negedge wb_clk);
      check_outputs();
      report_test("boot_reset", start_errs);

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* ctrl_core.f */
ctrl_core_pkg.sv
boot_reset_ctrl.sv
wb_slave_decode.sv
settings_regs.sv
readback_mux.sv
vita_timer.sv
ctrl_core.sv
tb_ctrl_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the control core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_ctrl_core \
   -f ctrl_core.f --Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_ctrl_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
